//--- link_pkg.sv
// link widths, opcodes, fifo depth, memory size, request payload union and response type.
`default_nettype none

package link_pkg;

   //////////////////////////////
   // field widths.
   localparam int ADDR_WIDTH   = 32;
   localparam int DATA_WIDTH   = 32;
   localparam int REG_ID_WIDTH = 5;

   // request opcodes.
   localparam logic OP_STORE = 1'b0;
   localparam logic OP_LOAD  = 1'b1;

   // the payload word carries store data, or the destination register of a load.
   typedef union packed {
      logic [DATA_WIDTH-1:0] store_data;
      struct packed {
         logic [DATA_WIDTH-REG_ID_WIDTH-1:0] unused;
         logic [REG_ID_WIDTH-1:0]            reg_id;
      } load;
   } req_payload_u;

   // forward packet is {opcode, address, payload}.
   localparam int FWD_PACKET_WIDTH = 1 + ADDR_WIDTH + DATA_WIDTH;

   typedef enum logic {
      RSP_STORE_ACK = 1'b0,
      RSP_LOAD_DATA = 1'b1
   } rsp_type_e;

   // return packet is {type, reg id, data}.
   localparam int REV_PACKET_WIDTH = 1 + REG_ID_WIDTH + DATA_WIDTH;

   //////////////////////////////
   // crossing and endpoint sizes.
   localparam int FIFO_LG_DEPTH  = 2;
   localparam int MEM_WORDS      = 16;
   localparam int MEM_ADDR_WIDTH = 4;

endpackage

`default_nettype wire

//--- async_fifo.sv
// dual-clock fifo with gray-code pointers and two-flop pointer synchronizers.
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
   parameter int WIDTH = 8
) (
   // write side.
   input  wire               w_clk_i,
   input  wire               w_reset_i,
   input  wire               w_enq_i,
   input  wire [WIDTH-1:0]   w_data_i,
   output logic              w_full_o,
   // read side.
   input  wire               r_clk_i,
   input  wire               r_reset_i,
   input  wire               r_deq_i,
   output logic [WIDTH-1:0]  r_data_o,
   output logic              r_valid_o
);

   // storage, indexed by the low pointer bits.
   logic [WIDTH-1:0] mem [2**link_pkg::FIFO_LG_DEPTH];

   // pointers carry one extra wrap bit.
   logic [link_pkg::FIFO_LG_DEPTH:0] w_bin;
   logic [link_pkg::FIFO_LG_DEPTH:0] w_bin_next;
   logic [link_pkg::FIFO_LG_DEPTH:0] w_gray;
   logic [link_pkg::FIFO_LG_DEPTH:0] w_rgray_meta;
   logic [link_pkg::FIFO_LG_DEPTH:0] w_rgray_sync;

   logic [link_pkg::FIFO_LG_DEPTH:0] r_bin;
   logic [link_pkg::FIFO_LG_DEPTH:0] r_bin_next;
   logic [link_pkg::FIFO_LG_DEPTH:0] r_gray;
   logic [link_pkg::FIFO_LG_DEPTH:0] r_wgray_meta;
   logic [link_pkg::FIFO_LG_DEPTH:0] r_wgray_sync;

   //////////////////////////////
   // write domain.
   assign w_bin_next = w_bin + (link_pkg::FIFO_LG_DEPTH + 1)'(1);

   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_bin  <= '0;
         w_gray <= '0;
      end else if (w_enq_i) begin
         w_bin  <= w_bin_next;
         w_gray <= w_bin_next ^ (w_bin_next >> 1);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_enq_i) begin
         mem[w_bin[link_pkg::FIFO_LG_DEPTH-1:0]] <= w_data_i;
      end
   end

   // read pointer brought over into the write clock.
   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_rgray_meta <= '0;
         w_rgray_sync <= '0;
      end else begin
         w_rgray_meta <= r_gray;
         w_rgray_sync <= w_rgray_meta;
      end
   end

   // full when the two top gray bits differ and the rest match.
   assign w_full_o = (w_gray == {~w_rgray_sync[link_pkg::FIFO_LG_DEPTH -: 2],
                                  w_rgray_sync[link_pkg::FIFO_LG_DEPTH-2:0]});

   //////////////////////////////
   // read domain.
   assign r_bin_next = r_bin + (link_pkg::FIFO_LG_DEPTH + 1)'(1);

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_bin  <= '0;
         r_gray <= '0;
      end else if (r_deq_i) begin
         r_bin  <= r_bin_next;
         r_gray <= r_bin_next ^ (r_bin_next >> 1);
      end
   end

   // write pointer brought over into the read clock.
   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_wgray_meta <= '0;
         r_wgray_sync <= '0;
      end else begin
         r_wgray_meta <= w_gray;
         r_wgray_sync <= r_wgray_meta;
      end
   end

   // entry is stable by the time its write pointer arrives here.
   assign r_data_o  = mem[r_bin[link_pkg::FIFO_LG_DEPTH-1:0]];
   assign r_valid_o = (r_gray != r_wgray_sync);

endmodule

`default_nettype wire

//--- link_async_buffer.sv
// forward and reverse channel crossing between the left and right clocks.
`timescale 1ns/100ps
`default_nettype none

module link_async_buffer (
   input  wire                                   l_clk_i,
   input  wire                                   r_clk_i,
   input  wire                                   reset_i,
   // forward channel, left in and right out.
   input  wire                                   l_fwd_v_i,
   input  wire [link_pkg::FWD_PACKET_WIDTH-1:0]  l_fwd_data_i,
   output logic                                  l_fwd_ready_o,
   output logic                                  r_fwd_v_o,
   output logic [link_pkg::FWD_PACKET_WIDTH-1:0] r_fwd_data_o,
   input  wire                                   r_fwd_ready_i,
   // reverse channel, right in and left out.
   input  wire                                   r_rev_v_i,
   input  wire [link_pkg::REV_PACKET_WIDTH-1:0]  r_rev_data_i,
   output logic                                  r_rev_ready_o,
   output logic                                  l_rev_v_o,
   output logic [link_pkg::REV_PACKET_WIDTH-1:0] l_rev_data_o,
   input  wire                                   l_rev_ready_i
);

   logic fwd_w_enq;
   logic fwd_w_full;
   logic fwd_r_deq;
   logic rev_w_enq;
   logic rev_w_full;
   logic rev_r_deq;

   //////////////////////////////
   // left to right forward.
   async_fifo #(.WIDTH(link_pkg::FWD_PACKET_WIDTH)) fwd_fifo (
      .w_clk_i   (l_clk_i),
      .w_reset_i (reset_i),
      .w_enq_i   (fwd_w_enq),
      .w_data_i  (l_fwd_data_i),
      .w_full_o  (fwd_w_full),
      .r_clk_i   (r_clk_i),
      .r_reset_i (reset_i),
      .r_deq_i   (fwd_r_deq),
      .r_data_o  (r_fwd_data_o),
      .r_valid_o (r_fwd_v_o)
   );

   assign fwd_w_enq     = l_fwd_v_i & ~fwd_w_full;
   assign l_fwd_ready_o = ~fwd_w_full;
   assign fwd_r_deq     = r_fwd_v_o & r_fwd_ready_i;

   //////////////////////////////
   // right to left reverse.
   async_fifo #(.WIDTH(link_pkg::REV_PACKET_WIDTH)) rev_fifo (
      .w_clk_i   (r_clk_i),
      .w_reset_i (reset_i),
      .w_enq_i   (rev_w_enq),
      .w_data_i  (r_rev_data_i),
      .w_full_o  (rev_w_full),
      .r_clk_i   (l_clk_i),
      .r_reset_i (reset_i),
      .r_deq_i   (rev_r_deq),
      .r_data_o  (l_rev_data_o),
      .r_valid_o (l_rev_v_o)
   );

   assign rev_w_enq     = r_rev_v_i & ~rev_w_full;
   assign r_rev_ready_o = ~rev_w_full;
   assign rev_r_deq     = l_rev_v_o & l_rev_ready_i;

endmodule

`default_nettype wire

//--- host_link_adapter.sv
// left-domain request packing and return packet splitting for the host.
`timescale 1ns/100ps
`default_nettype none

module host_link_adapter (
   input  wire                                   l_clk_i,
   input  wire                                   reset_i,
   // host request fields.
   input  wire                                   req_v_i,
   input  wire                                   req_op_i,
   input  wire [link_pkg::ADDR_WIDTH-1:0]        req_addr_i,
   input  wire [link_pkg::DATA_WIDTH-1:0]        req_payload_i,
   output logic                                  req_ready_o,
   // forward packet toward the crossing.
   output logic                                  fwd_v_o,
   output logic [link_pkg::FWD_PACKET_WIDTH-1:0] fwd_data_o,
   input  wire                                   fwd_ready_i,
   // return packet from the crossing.
   input  wire                                   rev_v_i,
   input  wire [link_pkg::REV_PACKET_WIDTH-1:0]  rev_data_i,
   output logic                                  rev_ready_o,
   // host response fields.
   output logic                                  rsp_v_o,
   output link_pkg::rsp_type_e                   rsp_type_o,
   output logic [link_pkg::REG_ID_WIDTH-1:0]     rsp_reg_id_o,
   output logic [link_pkg::DATA_WIDTH-1:0]       rsp_data_o,
   input  wire                                   rsp_ready_i
);

   //////////////////////////////
   // forward output register.
   // free when empty or being drained this cycle.
   assign req_ready_o = ~fwd_v_o | fwd_ready_i;

   always_ff @(posedge l_clk_i) begin
      if (reset_i) begin
         fwd_v_o <= 1'b0;
      end else if (req_ready_o) begin
         fwd_v_o <= req_v_i;
      end
   end

   always_ff @(posedge l_clk_i) begin
      if (req_v_i & req_ready_o) begin
         fwd_data_o <= {req_op_i, req_addr_i, req_payload_i};
      end
   end

   //////////////////////////////
   // return path, no storage.
   assign rsp_v_o      = rev_v_i;
   assign rsp_type_o   = link_pkg::rsp_type_e'(rev_data_i[link_pkg::REV_PACKET_WIDTH-1]);
   assign rsp_reg_id_o = rev_data_i[link_pkg::DATA_WIDTH +: link_pkg::REG_ID_WIDTH];
   assign rsp_data_o   = rev_data_i[link_pkg::DATA_WIDTH-1:0];
   assign rev_ready_o  = rsp_ready_i;

endmodule

`default_nettype wire

//--- remote_mem_endpoint.sv
// right-domain memory endpoint serving stores and loads with one return register.
`timescale 1ns/100ps
`default_nettype none

module remote_mem_endpoint (
   input  wire                                   r_clk_i,
   input  wire                                   reset_i,
   // incoming requests.
   input  wire                                   fwd_v_i,
   input  wire [link_pkg::FWD_PACKET_WIDTH-1:0]  fwd_data_i,
   output logic                                  fwd_ready_o,
   // outgoing returns.
   output logic                                  rev_v_o,
   output logic [link_pkg::REV_PACKET_WIDTH-1:0] rev_data_o,
   input  wire                                   rev_ready_i
);

   logic [link_pkg::DATA_WIDTH-1:0]     mem [link_pkg::MEM_WORDS];

   logic                                fwd_op;
   logic [link_pkg::ADDR_WIDTH-1:0]     fwd_addr;
   link_pkg::req_payload_u              fwd_payload;
   logic [link_pkg::MEM_ADDR_WIDTH-1:0] mem_idx;
   logic                                accept;

   //////////////////////////////
   // request decode.
   assign fwd_op      = fwd_data_i[link_pkg::FWD_PACKET_WIDTH-1];
   assign fwd_addr    = fwd_data_i[link_pkg::DATA_WIDTH +: link_pkg::ADDR_WIDTH];
   assign fwd_payload = fwd_data_i[link_pkg::DATA_WIDTH-1:0];

   // word address, byte offset dropped.
   assign mem_idx = fwd_addr[2 +: link_pkg::MEM_ADDR_WIDTH];

   // accept while the return register is empty or draining.
   assign fwd_ready_o = ~rev_v_o | rev_ready_i;
   assign accept      = fwd_v_i & fwd_ready_o;

   //////////////////////////////
   // memory, cleared on reset.
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (accept && fwd_op == link_pkg::OP_STORE) begin
         mem[mem_idx] <= fwd_payload.store_data;
      end
   end

   //////////////////////////////
   // return register.
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         rev_v_o <= 1'b0;
      end else if (fwd_ready_o) begin
         rev_v_o <= fwd_v_i;
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (accept) begin
         if (fwd_op == link_pkg::OP_LOAD) begin
            // load reads the word before any store of this same cycle.
            rev_data_o <= {link_pkg::RSP_LOAD_DATA,
                           fwd_payload.load.reg_id,
                           mem[mem_idx]};
         end else begin
            rev_data_o <= {link_pkg::RSP_STORE_ACK,
                           {link_pkg::REG_ID_WIDTH{1'b0}},
                           {link_pkg::DATA_WIDTH{1'b0}}};
         end
      end
   end

endmodule

`default_nettype wire

//--- link_cdc_top.sv
// top level joining host adapter, async crossing buffer and memory endpoint.
`timescale 1ns/100ps
`default_nettype none

module link_cdc_top (
   input  wire                                l_clk_i,
   input  wire                                r_clk_i,
   input  wire                                reset_i,
   // host requests.
   input  wire                                req_v_i,
   input  wire                                req_op_i,
   input  wire [link_pkg::ADDR_WIDTH-1:0]     req_addr_i,
   input  wire [link_pkg::DATA_WIDTH-1:0]     req_payload_i,
   output logic                               req_ready_o,
   // host responses.
   output logic                               rsp_v_o,
   output link_pkg::rsp_type_e                rsp_type_o,
   output logic [link_pkg::REG_ID_WIDTH-1:0]  rsp_reg_id_o,
   output logic [link_pkg::DATA_WIDTH-1:0]    rsp_data_o,
   input  wire                                rsp_ready_i
);

   // left domain side of the crossing.
   logic                                  l_fwd_v;
   logic [link_pkg::FWD_PACKET_WIDTH-1:0] l_fwd_data;
   logic                                  l_fwd_ready;
   logic                                  l_rev_v;
   logic [link_pkg::REV_PACKET_WIDTH-1:0] l_rev_data;
   logic                                  l_rev_ready;

   // right domain side of the crossing.
   logic                                  r_fwd_v;
   logic [link_pkg::FWD_PACKET_WIDTH-1:0] r_fwd_data;
   logic                                  r_fwd_ready;
   logic                                  r_rev_v;
   logic [link_pkg::REV_PACKET_WIDTH-1:0] r_rev_data;
   logic                                  r_rev_ready;

   host_link_adapter u_host (
      .l_clk_i       (l_clk_i),
      .reset_i       (reset_i),
      .req_v_i       (req_v_i),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_payload_i (req_payload_i),
      .req_ready_o   (req_ready_o),
      .fwd_v_o       (l_fwd_v),
      .fwd_data_o    (l_fwd_data),
      .fwd_ready_i   (l_fwd_ready),
      .rev_v_i       (l_rev_v),
      .rev_data_i    (l_rev_data),
      .rev_ready_o   (l_rev_ready),
      .rsp_v_o       (rsp_v_o),
      .rsp_type_o    (rsp_type_o),
      .rsp_reg_id_o  (rsp_reg_id_o),
      .rsp_data_o    (rsp_data_o),
      .rsp_ready_i   (rsp_ready_i)
   );

   link_async_buffer u_buffer (
      .l_clk_i       (l_clk_i),
      .r_clk_i       (r_clk_i),
      .reset_i       (reset_i),
      .l_fwd_v_i     (l_fwd_v),
      .l_fwd_data_i  (l_fwd_data),
      .l_fwd_ready_o (l_fwd_ready),
      .r_fwd_v_o     (r_fwd_v),
      .r_fwd_data_o  (r_fwd_data),
      .r_fwd_ready_i (r_fwd_ready),
      .r_rev_v_i     (r_rev_v),
      .r_rev_data_i  (r_rev_data),
      .r_rev_ready_o (r_rev_ready),
      .l_rev_v_o     (l_rev_v),
      .l_rev_data_o  (l_rev_data),
      .l_rev_ready_i (l_rev_ready)
   );

   remote_mem_endpoint u_endpoint (
      .r_clk_i     (r_clk_i),
      .reset_i     (reset_i),
      .fwd_v_i     (r_fwd_v),
      .fwd_data_i  (r_fwd_data),
      .fwd_ready_o (r_fwd_ready),
      .rev_v_o     (r_rev_v),
      .rev_data_o  (r_rev_data),
      .rev_ready_i (r_rev_ready)
   );

endmodule

`default_nettype wire

//--- tb_link_cdc.sv
// testbench for the link crossing with lfsr stimulus, reference model and response checks.
`timescale 1ns/100ps
`default_nettype none

module tb_link_cdc;

   logic                              l_clk_i = 1'b0;
   logic                              r_clk_i = 1'b0;
   logic                              reset_i;
   logic                              req_v_i;
   logic                              req_op_i;
   logic [link_pkg::ADDR_WIDTH-1:0]   req_addr_i;
   logic [link_pkg::DATA_WIDTH-1:0]   req_payload_i;
   logic                              req_ready_o;
   logic                              rsp_v_o;
   link_pkg::rsp_type_e               rsp_type_o;
   logic [link_pkg::REG_ID_WIDTH-1:0] rsp_reg_id_o;
   logic [link_pkg::DATA_WIDTH-1:0]   rsp_data_o;
   logic                              rsp_ready_i;

   // model memory and expected responses in issue order.
   logic [link_pkg::DATA_WIDTH-1:0]   model_mem [link_pkg::MEM_WORDS];
   link_pkg::rsp_type_e               exp_type_q [$];
   logic [link_pkg::REG_ID_WIDTH-1:0] exp_reg_id_q [$];
   logic [link_pkg::DATA_WIDTH-1:0]   exp_data_q [$];
   logic [31:0]                       lfsr_state = 32'h62310cc8;
   logic                              random_ready = 1'b0;

   link_cdc_top u_dut (
      .l_clk_i       (l_clk_i),
      .r_clk_i       (r_clk_i),
      .reset_i       (reset_i),
      .req_v_i       (req_v_i),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_payload_i (req_payload_i),
      .req_ready_o   (req_ready_o),
      .rsp_v_o       (rsp_v_o),
      .rsp_type_o    (rsp_type_o),
      .rsp_reg_id_o  (rsp_reg_id_o),
      .rsp_data_o    (rsp_data_o),
      .rsp_ready_i   (rsp_ready_i)
   );

   // the 40 ns left and 56 ns right periods are unrelated.
   always #20 l_clk_i = ~l_clk_i;
   always #28 r_clk_i = ~r_clk_i;

   //////////////////////////////
   // random source and reference model.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      // taps 32, 22, 2 and 1.
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // word index is address bits 5:2 and the reg id sits in the low payload bits.
   function automatic void predict_response(input logic op, input logic [31:0] addr,
                                            input logic [31:0] payload);
      logic [3:0] idx;
      idx = addr[5:2];
      if (op == link_pkg::OP_STORE) begin
         model_mem[idx] = payload;
         exp_type_q.push_back(link_pkg::RSP_STORE_ACK);
         exp_reg_id_q.push_back('0);
         exp_data_q.push_back('0);
      end else begin
         exp_type_q.push_back(link_pkg::RSP_LOAD_DATA);
         exp_reg_id_q.push_back(payload[link_pkg::REG_ID_WIDTH-1:0]);
         exp_data_q.push_back(model_mem[idx]);
      end
   endfunction

   function automatic logic [31:0] store_word(input logic [3:0] idx);
      return 32'h5a3c_0000 ^ {8{idx}};
   endfunction

   //////////////////////////////
   // compare tasks.
   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_rsp_type(input link_pkg::rsp_type_e exp, input link_pkg::rsp_type_e act);
      if (act !== exp) begin
         $display("FAIL rsp_type_o expected %h got %h", exp, act);
         abort_run();
      end
   endtask

   task automatic check_reg_id(input logic [link_pkg::REG_ID_WIDTH-1:0] exp,
                               input logic [link_pkg::REG_ID_WIDTH-1:0] act);
      if (act !== exp) begin
         $display("FAIL rsp_reg_id_o expected %h got %h", exp, act);
         abort_run();
      end
   endtask

   task automatic check_data(input logic [link_pkg::DATA_WIDTH-1:0] exp,
                             input logic [link_pkg::DATA_WIDTH-1:0] act);
      if (act !== exp) begin
         $display("FAIL rsp_data_o expected %h got %h", exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s expected %h got %h", name, exp, act);
         abort_run();
      end
   endtask

   // every accepted response is held against the queue front.
   always @(posedge l_clk_i) begin
      if (!reset_i && rsp_v_o && rsp_ready_i) begin
         if (exp_type_q.size() == 0) begin
            $display("a response arrived while no request was outstanding");
            abort_run();
         end else begin
            check_rsp_type(exp_type_q.pop_front(), rsp_type_o);
            check_reg_id(exp_reg_id_q.pop_front(), rsp_reg_id_o);
            check_data(exp_data_q.pop_front(), rsp_data_o);
         end
      end
   end

   //////////////////////////////
   // stimulus tasks.
   task automatic update_rsp_ready();
      if (random_ready) begin
         rsp_ready_i = (random_bits(1) != 32'd0);
      end
   endtask

   task automatic next_cycle();
      @(posedge l_clk_i);
      #2;
      update_rsp_ready();
   endtask

   // holds the request until accepted or the window runs out.
   task automatic send_request(input logic op, input logic [31:0] addr,
                               input logic [31:0] payload, input int window,
                               output logic accepted);
      int waited;
      waited = 0;
      accepted = 1'b0;
      req_v_i = 1'b1;
      req_op_i = op;
      req_addr_i = addr;
      req_payload_i = payload;
      while (!accepted && waited < window) begin
         @(posedge l_clk_i);
         accepted = req_ready_o;
         waited++;
         #2;
         update_rsp_ready();
      end
      req_v_i = 1'b0;
      if (accepted) begin
         predict_response(op, addr, payload);
      end
   endtask

   task automatic issue(input logic op, input logic [31:0] addr, input logic [31:0] payload);
      logic ok;
      send_request(op, addr, payload, 200, ok);
      if (!ok) begin
         $display("req_ready_o did not rise within 200 cycles");
         abort_run();
      end
   endtask

   task automatic wait_drained(input int limit);
      int waited;
      waited = 0;
      while (exp_type_q.size() != 0) begin
         if (waited == limit) begin
            $display("%0d responses still missing after %0d cycles", exp_type_q.size(), limit);
            abort_run();
         end
         next_cycle();
         waited++;
      end
   endtask

   //////////////////////////////
   // test sequence.
   initial begin
      int  held;
      int  gap;
      logic ok;
      logic op;
      reset_i = 1'b1;
      req_v_i = 1'b0;
      req_op_i = 1'b0;
      req_addr_i = '0;
      req_payload_i = '0;
      rsp_ready_i = 1'b1;
      for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      repeat (4) @(posedge l_clk_i);
      #2;
      reset_i = 1'b0;

      // idle after reset.
      repeat (20) begin
         @(posedge l_clk_i);
         check_flag("rsp_v_o", 1'b0, rsp_v_o);
         check_flag("req_ready_o", 1'b1, req_ready_o);
         #2;
      end

      // never-written words read back as zero.
      for (int i = 0; i < 4; i++) begin
         issue(link_pkg::OP_LOAD, i * 4, 32'hfff0_0000 | (i + 1));
      end
      wait_drained(400);

      // store every word, then load with distinct reg ids.
      for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
         issue(link_pkg::OP_STORE, i * 4, store_word(4'(i)));
      end
      for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
         issue(link_pkg::OP_LOAD, i * 4, 32'hfff0_0000 | (i + 7));
      end
      wait_drained(400);

      // high address bits are ignored by the endpoint.
      for (int i = 0; i < link_pkg::MEM_WORDS; i++) begin
         issue(link_pkg::OP_LOAD, 32'h1234_5640 + i * 4, i + 3);
      end
      issue(link_pkg::OP_STORE, 32'hffff_ffc8, 32'hdead_beef);
      issue(link_pkg::OP_LOAD, 32'h0000_0008, 32'd30);
      wait_drained(400);

      // stalled responses let at most 4 per fifo plus 2 registers fill.
      rsp_ready_i = 1'b0;
      held = 0;
      ok = 1'b1;
      while (ok && held < 20) begin
         send_request(held[0], held * 4, 32'h0bad_0000 | held, 40, ok);
         if (ok) begin
            held++;
         end
      end
      if (held > 10) begin
         $display("%0d requests accepted while responses were stalled, capacity is 10", held);
         abort_run();
      end
      rsp_ready_i = 1'b1;
      wait_drained(400);

      // random traffic with random response stalls.
      random_ready = 1'b1;
      for (int n = 0; n < 300; n++) begin
         gap = int'(random_bits(2));
         repeat (gap) next_cycle();
         op = (random_bits(1) != 32'd0);
         issue(op, random_bits(32), random_bits(32));
      end
      wait_drained(3000);
      random_ready = 1'b0;
      rsp_ready_i = 1'b1;

      // no response may follow once every request is answered.
      repeat (20) begin
         @(posedge l_clk_i);
         check_flag("rsp_v_o", 1'b0, rsp_v_o);
         #2;
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
link_pkg.sv
async_fifo.sv
link_async_buffer.sv
host_link_adapter.sv
remote_mem_endpoint.sv
link_cdc_top.sv
tb_link_cdc.sv

//--- run.sh
#!/bin/sh
# build the link crossing testbench with verilator, run it and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
   -f filelist.f --top-module tb_link_cdc -o sim_link_cdc

# the simulator exits non-zero on a fatal error, so the log decides.
./obj_dir/sim_link_cdc > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
   exit 0
else
   exit 1
fi
